/* logic/cnn_pkg.sv */
`default_nettype none

package cnn_pkg;

	typedef enum logic [3:0] {
		op_pool = 4'd2,
		op_fc   = 4'd3,
		op_end  = 4'd4
	} op_t;

	typedef logic signed [31:0] word_t;
	typedef logic [11:0]        faddr_t;
	typedef logic [15:0]        waddr_t;
	typedef logic [7:0]         count8_t;
	typedef logic [13:0]        size14_t;
	typedef logic signed [63:0] acc_t;

	typedef enum logic [2:0] {
		idle,
		fetch_addr,
		fetch_data,
		decode,
		run
	} fetch_state_t;

	////////////////////////////////////////////////////////////
	// Memory map and arithmetic
	////////////////////////////////////////////////////////////
	localparam faddr_t pc_reset      = 12'd4095; // Program sits at the top of feature memory
	localparam faddr_t pool_out_base = 12'd2048;
	localparam faddr_t fc_out_base   = 12'd3072;
	localparam int     frac_bits     = 27; // FC result is acc[58:27]
	localparam int     pool_win      = 2;

	////////////////////////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////////////////////////
	localparam int op_hi        = 31;
	localparam int op_lo        = 28;
	localparam int pool_ch_hi   = 27;
	localparam int pool_ch_lo   = 20;
	localparam int pool_side_hi = 13;
	localparam int pool_side_lo = 0;
	localparam int fc_feat_hi   = 27;
	localparam int fc_feat_lo   = 20;
	localparam int fc_side_hi   = 19;
	localparam int fc_side_lo   = 14;
	localparam int fc_class_hi  = 13;
	localparam int fc_class_lo  = 10;
	localparam int fc_wbase_hi  = 9;
	localparam int fc_wbase_lo  = 0;

endpackage

`default_nettype wire

/* logic/layer_cmd_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface layer_cmd_if;
	logic             go;          // One cycle, in decode
	cnn_pkg::op_t     op;
	cnn_pkg::count8_t channels;    // Pool channels or FC feature count
	cnn_pkg::size14_t map_size;
	cnn_pkg::count8_t class_num;
	cnn_pkg::waddr_t  fc_len;      // Features times side squared
	cnn_pkg::waddr_t  weight_base;

	modport sequencer (
		output go, op, channels, map_size, class_num, fc_len, weight_base
	);

	modport engine (
		input go, op, channels, map_size, class_num, fc_len, weight_base
	);
endinterface

`default_nettype wire

/* logic/engine_out_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface engine_out_if;
	logic             rd_en;     // Held while the engine reads feature memory
	cnn_pkg::faddr_t  rd_addr;
	logic             res_valid; // One cycle per result
	logic             res_last;  // Final result of the layer
	cnn_pkg::word_t   res_data;

	modport engine (
		output rd_en, rd_addr, res_valid, res_last, res_data
	);

	modport writer (
		input rd_en, rd_addr, res_valid, res_last, res_data
	);
endinterface

`default_nettype wire

/* logic/instr_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_fetch (
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  cnn_pkg::word_t   feature_idata,
	input  logic             instruction_finish,
	output logic             fetch_en,
	output cnn_pkg::faddr_t  fetch_addr,
	output logic             done,
	layer_cmd_if.sequencer   cmd
);

	cnn_pkg::fetch_state_t state, next_state;
	cnn_pkg::faddr_t       pc;
	cnn_pkg::word_t        instr;
	cnn_pkg::op_t          op;
	cnn_pkg::waddr_t       fc_feat;
	cnn_pkg::waddr_t       fc_side;

	always_comb begin
		next_state = state;
		case (state)
			cnn_pkg::idle:       if (start) next_state = cnn_pkg::fetch_addr;
			cnn_pkg::fetch_addr: next_state = cnn_pkg::fetch_data;
			cnn_pkg::fetch_data: next_state = cnn_pkg::decode;
			cnn_pkg::decode: begin
				case (op)
					cnn_pkg::op_end:  next_state = cnn_pkg::idle;
					cnn_pkg::op_pool,
					cnn_pkg::op_fc:   next_state = cnn_pkg::run;
					default:          next_state = cnn_pkg::fetch_addr; // Skip unknown opcodes
				endcase
			end
			cnn_pkg::run:        if (instruction_finish) next_state = cnn_pkg::fetch_addr;
			default:             next_state = cnn_pkg::idle;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= cnn_pkg::idle;
			pc    <= cnn_pkg::pc_reset;
			done  <= 1'b0;
		end else begin
			state <= next_state;
			if (state == cnn_pkg::fetch_data)
				pc <= pc - 1'b1; // Program runs downward
			if (state == cnn_pkg::decode && op == cnn_pkg::op_end)
				done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (state == cnn_pkg::fetch_data)
			instr <= feature_idata;
	end

	assign fetch_en   = (state == cnn_pkg::fetch_addr) || (state == cnn_pkg::fetch_data);
	assign fetch_addr = pc;

	////////////////////////////////////////////////////////////
	// Field decode
	////////////////////////////////////////////////////////////
	assign op      = cnn_pkg::op_t'(instr[cnn_pkg::op_hi:cnn_pkg::op_lo]);
	assign fc_feat = cnn_pkg::waddr_t'(instr[cnn_pkg::fc_feat_hi:cnn_pkg::fc_feat_lo]);
	assign fc_side = cnn_pkg::waddr_t'(instr[cnn_pkg::fc_side_hi:cnn_pkg::fc_side_lo]);

	assign cmd.go          = (state == cnn_pkg::decode) &&
	                         (op == cnn_pkg::op_pool || op == cnn_pkg::op_fc);
	assign cmd.op          = op;
	assign cmd.channels    = instr[cnn_pkg::pool_ch_hi:cnn_pkg::pool_ch_lo];
	assign cmd.map_size    = (op == cnn_pkg::op_fc) ?
	                         cnn_pkg::size14_t'(instr[cnn_pkg::fc_side_hi:cnn_pkg::fc_side_lo]) :
	                         instr[cnn_pkg::pool_side_hi:cnn_pkg::pool_side_lo];
	assign cmd.class_num   = cnn_pkg::count8_t'(instr[cnn_pkg::fc_class_hi:cnn_pkg::fc_class_lo]);
	assign cmd.fc_len      = fc_feat * fc_side * fc_side;
	assign cmd.weight_base = cnn_pkg::waddr_t'(instr[cnn_pkg::fc_wbase_hi:cnn_pkg::fc_wbase_lo]);

endmodule

`default_nettype wire

/* logic/pool_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module pool_engine (
	input  logic           clk,
	input  logic           reset,
	input  cnn_pkg::word_t feature_idata,
	layer_cmd_if.engine    cmd,
	engine_out_if.engine   rd
);

	logic             busy;
	logic [1:0]       pos;     // Tap inside the window
	logic [1:0]       hold;    // Result and write cycles between windows
	cnn_pkg::count8_t ch, ch_num;
	cnn_pkg::size14_t wx, wy, side, half;
	cnn_pkg::faddr_t  side_a, row_idx, col_idx;
	cnn_pkg::word_t   max_q;
	logic             start_pool, reading, last_pos, last_col, last_row, last_ch;
	logic             valid_q, last_q;

	assign start_pool = cmd.go && (cmd.op == cnn_pkg::op_pool);
	assign reading    = busy && (hold == 2'd0);
	assign last_pos   = (pos == 2'(cnn_pkg::pool_win * cnn_pkg::pool_win - 1));
	assign last_col   = (wx == half - 1'b1);
	assign last_row   = (wy == half - 1'b1);
	assign last_ch    = (ch == ch_num - 1'b1);

	assign side_a  = cnn_pkg::faddr_t'(side);
	assign row_idx = cnn_pkg::faddr_t'(wy) * cnn_pkg::faddr_t'(cnn_pkg::pool_win) +
	                 cnn_pkg::faddr_t'(pos[1]);
	assign col_idx = cnn_pkg::faddr_t'(wx) * cnn_pkg::faddr_t'(cnn_pkg::pool_win) +
	                 cnn_pkg::faddr_t'(pos[0]);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy   <= 1'b0;
			pos    <= '0;
			hold   <= '0;
			ch     <= '0;
			wx     <= '0;
			wy     <= '0;
			ch_num <= '0;
			side   <= '0;
			half   <= '0;
		end else if (start_pool) begin
			busy   <= 1'b1;
			pos    <= '0;
			hold   <= '0;
			ch     <= '0;
			wx     <= '0;
			wy     <= '0;
			ch_num <= cmd.channels;
			side   <= cmd.map_size;
			half   <= cnn_pkg::size14_t'(cmd.map_size / cnn_pkg::size14_t'(cnn_pkg::pool_win));
		end else if (busy) begin
			if (hold != 2'd0) begin
				hold <= hold - 2'd1;
			end else if (last_pos) begin
				pos  <= '0;
				hold <= 2'd2;
				if (!last_col) begin
					wx <= wx + 1'b1;
				end else begin
					wx <= '0;
					if (!last_row) begin
						wy <= wy + 1'b1;
					end else begin
						wy <= '0;
						if (last_ch)
							busy <= 1'b0;
						else
							ch <= ch + 1'b1;
					end
				end
			end else begin
				pos <= pos + 2'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reading && (pos == 2'd0 || feature_idata > max_q))
			max_q <= feature_idata; // First tap seeds the maximum
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= 1'b0;
			last_q  <= 1'b0;
		end else begin
			valid_q <= reading && last_pos;
			last_q  <= reading && last_pos && last_col && last_row && last_ch;
		end
	end

	assign rd.rd_en     = reading;
	assign rd.rd_addr   = cnn_pkg::faddr_t'(ch) * side_a * side_a + row_idx * side_a + col_idx;
	assign rd.res_valid = valid_q;
	assign rd.res_last  = last_q;
	assign rd.res_data  = max_q;

endmodule

`default_nettype wire

/* logic/fc_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module fc_engine (
	input  logic            clk,
	input  logic            reset,
	input  cnn_pkg::word_t  feature_idata,
	input  cnn_pkg::word_t  weight_idata,
	layer_cmd_if.engine     cmd,
	output cnn_pkg::waddr_t weight_addr,
	engine_out_if.engine    rd
);

	logic             busy;
	logic [1:0]       hold;
	cnn_pkg::waddr_t  idx, len;
	cnn_pkg::count8_t cls, cls_num;
	cnn_pkg::acc_t    acc, prod;
	logic             start_fc, reading, last_elem, last_cls;
	logic             valid_q, last_q;

	assign start_fc  = cmd.go && (cmd.op == cnn_pkg::op_fc);
	assign reading   = busy && (hold == 2'd0);
	assign last_elem = (idx == len - 1'b1);
	assign last_cls  = (cls == cls_num - 1'b1);
	assign prod      = cnn_pkg::acc_t'(feature_idata) * cnn_pkg::acc_t'(weight_idata);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy        <= 1'b0;
			hold        <= '0;
			idx         <= '0;
			len         <= '0;
			cls         <= '0;
			cls_num     <= '0;
			weight_addr <= '0;
		end else if (start_fc) begin
			busy        <= 1'b1;
			hold        <= '0;
			idx         <= '0;
			len         <= cmd.fc_len;
			cls         <= '0;
			cls_num     <= cmd.class_num;
			weight_addr <= cmd.weight_base;
		end else if (busy) begin
			if (hold != 2'd0) begin
				hold <= hold - 2'd1;
			end else begin
				weight_addr <= weight_addr + 1'b1; // Runs on into the next class rows
				if (last_elem) begin
					idx  <= '0;
					hold <= 2'd2;
					if (last_cls)
						busy <= 1'b0;
					else
						cls <= cls + 1'b1;
				end else begin
					idx <= idx + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reading) begin
			if (idx == '0)
				acc <= prod; // New class starts from zero
			else
				acc <= acc + prod;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= 1'b0;
			last_q  <= 1'b0;
		end else begin
			valid_q <= reading && last_elem;
			last_q  <= reading && last_elem && last_cls;
		end
	end

	assign rd.rd_en     = reading;
	assign rd.rd_addr   = cnn_pkg::faddr_t'(idx);
	assign rd.res_valid = valid_q;
	assign rd.res_last  = last_q;
	assign rd.res_data  = acc[cnn_pkg::frac_bits +: 32];

endmodule

`default_nettype wire

/* logic/result_writer.sv */
`timescale 1ns/1ns
`default_nettype none

module result_writer (
	input  logic            clk,
	input  logic            reset,
	input  logic            fetch_en,
	input  cnn_pkg::faddr_t fetch_addr,
	engine_out_if.writer    pool,
	engine_out_if.writer    fc,
	output cnn_pkg::faddr_t feature_addr,
	output cnn_pkg::word_t  feature_data,
	output logic            feature_mem_en,
	output logic            instruction_finish
);

	logic            wr_is_fc;
	cnn_pkg::faddr_t pool_idx, fc_idx, wr_addr;
	cnn_pkg::word_t  wr_data;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			feature_mem_en     <= 1'b0;
			instruction_finish <= 1'b0;
			wr_is_fc           <= 1'b0;
			pool_idx           <= '0;
			fc_idx             <= '0;
		end else begin
			feature_mem_en     <= pool.res_valid || fc.res_valid;
			instruction_finish <= (pool.res_valid && pool.res_last) ||
			                      (fc.res_valid && fc.res_last);
			if (pool.res_valid)
				wr_is_fc <= 1'b0;
			else if (fc.res_valid)
				wr_is_fc <= 1'b1;
			if (feature_mem_en) begin
				// The finish pulse marks the layer's last write
				if (wr_is_fc)
					fc_idx <= instruction_finish ? '0 : fc_idx + 1'b1;
				else
					pool_idx <= instruction_finish ? '0 : pool_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pool.res_valid)
			wr_data <= pool.res_data;
		else if (fc.res_valid)
			wr_data <= fc.res_data;
	end

	assign wr_addr = wr_is_fc ? cnn_pkg::fc_out_base + fc_idx : cnn_pkg::pool_out_base + pool_idx;

	always_comb begin
		if (feature_mem_en)
			feature_addr = wr_addr;
		else if (fetch_en)
			feature_addr = fetch_addr;
		else if (pool.rd_en)
			feature_addr = pool.rd_addr;
		else if (fc.rd_en)
			feature_addr = fc.rd_addr;
		else
			feature_addr = '0;
	end

	assign feature_data = wr_data;

endmodule

`default_nettype wire

/* logic/cnn_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module cnn_ctrl (
	input  logic            clk,
	input  logic            reset,
	input  logic            start,
	input  cnn_pkg::word_t  feature_idata,
	input  cnn_pkg::word_t  weight_idata,
	output cnn_pkg::faddr_t feature_addr,
	output cnn_pkg::word_t  feature_data,
	output cnn_pkg::waddr_t weight_addr,
	output logic            feature_mem_en,
	output logic            instruction_finish,
	output logic            done
);

	logic            fetch_en;
	cnn_pkg::faddr_t fetch_addr;

	layer_cmd_if  cmd ();
	engine_out_if pool_rd ();
	engine_out_if fc_rd ();

	instr_fetch u_instr_fetch (
		.clk                (clk),
		.reset              (reset),
		.start              (start),
		.feature_idata      (feature_idata),
		.instruction_finish (instruction_finish),
		.fetch_en           (fetch_en),
		.fetch_addr         (fetch_addr),
		.done               (done),
		.cmd                (cmd.sequencer)
	);

	pool_engine u_pool_engine (
		.clk           (clk),
		.reset         (reset),
		.feature_idata (feature_idata),
		.cmd           (cmd.engine),
		.rd            (pool_rd.engine)
	);

	fc_engine u_fc_engine (
		.clk           (clk),
		.reset         (reset),
		.feature_idata (feature_idata),
		.weight_idata  (weight_idata),
		.cmd           (cmd.engine),
		.weight_addr   (weight_addr),
		.rd            (fc_rd.engine)
	);

	result_writer u_result_writer (
		.clk                (clk),
		.reset              (reset),
		.fetch_en           (fetch_en),
		.fetch_addr         (fetch_addr),
		.pool               (pool_rd.writer),
		.fc                 (fc_rd.writer),
		.feature_addr       (feature_addr),
		.feature_data       (feature_data),
		.feature_mem_en     (feature_mem_en),
		.instruction_finish (instruction_finish)
	);

endmodule

`default_nettype wire

/* tb/cnn_ctrl_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module cnn_ctrl_chk (
	input logic clk,
	input logic reset,
	input logic feature_mem_en,
	input logic instruction_finish,
	input logic done
);

	int fail_count = 0;

	a_single_write: assert property (
		@(posedge clk) disable iff (reset) feature_mem_en |=> !feature_mem_en
	) else begin
		fail_count++;
		$error("feature_mem_en stayed high for two cycles");
	end

	a_finish_on_write: assert property (
		@(posedge clk) disable iff (reset) instruction_finish |-> feature_mem_en
	) else begin
		fail_count++;
		$error("instruction_finish without a feature write");
	end

	a_done_sticky: assert property (
		@(posedge clk) disable iff (reset) done |=> done
	) else begin
		fail_count++;
		$error("done fell while reset was low");
	end

endmodule

`default_nettype wire

/* tb/write_monitor.sv */
`timescale 1ns/1ns
`default_nettype none

module write_monitor (
	input  logic            clk,
	input  logic            reset,
	input  cnn_pkg::faddr_t feature_addr,
	input  cnn_pkg::word_t  feature_data,
	input  logic            feature_mem_en,
	input  logic            instruction_finish,
	input  logic            done,
	output int              errors,
	output int              writes,
	output int              finishes,
	output int              pending
);

	cnn_pkg::faddr_t exp_addr [$];
	cnn_pkg::word_t  exp_data [$];
	logic            exp_last [$];
	logic            after_finish;
	cnn_pkg::faddr_t next_pc;

	initial begin
		errors       = 0;
		writes       = 0;
		finishes     = 0;
		pending      = 0;
		after_finish = 1'b0;
	end

	task automatic expect_write(input cnn_pkg::faddr_t addr, input cnn_pkg::word_t data,
	                            input logic last);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_last.push_back(last);
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] expected);
		if (got !== expected) begin
			$display("ERR %s got %h expected %h", name, got, expected);
			errors++;
		end
	endtask

	// Outputs settle after the rising edge, so the falling edge sees them stable
	always @(negedge clk) begin
		if (!reset) begin
			if (after_finish) begin
				next_pc = 12'(cnn_pkg::pc_reset - finishes); // Next instruction sits one lower
				compare("feature_addr", feature_addr, next_pc);
			end
			after_finish = 1'b0;
			if (feature_mem_en) begin
				writes++;
				if (done) begin
					$display("A feature write happened after done, at address %h", feature_addr);
					errors++;
				end
				if (exp_addr.size() == 0) begin
					$display("A feature write happened with no write expected, address %h",
					         feature_addr);
					errors++;
				end else begin
					compare("feature_addr", feature_addr, exp_addr[0]);
					compare("feature_data", feature_data, exp_data[0]);
					compare("instruction_finish", instruction_finish, exp_last[0]);
					void'(exp_addr.pop_front());
					void'(exp_data.pop_front());
					void'(exp_last.pop_front());
				end
			end else if (instruction_finish) begin
				$display("instruction_finish pulsed in a cycle without a feature write");
				errors++;
			end
			if (instruction_finish) begin
				finishes++;
				after_finish = 1'b1;
			end
		end
		pending = exp_addr.size();
	end

endmodule

`default_nettype wire

/* tb/cnn_ctrl_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cnn_ctrl_tb;

	localparam int n_rows    = 5;
	localparam int clk_half  = 10;
	localparam int reset_len = 10;

	typedef struct packed {
		cnn_pkg::op_t op;
		int unsigned  cnt;    // Pool channels or FC feature count
		int unsigned  side;
		int unsigned  cls;
		int unsigned  wbase;
		int unsigned  writes;
	} row_t;

	logic            clk;
	logic            reset;
	logic            start;
	cnn_pkg::word_t  feature_idata;
	cnn_pkg::word_t  weight_idata;
	cnn_pkg::faddr_t feature_addr;
	cnn_pkg::word_t  feature_data;
	cnn_pkg::waddr_t weight_addr;
	logic            feature_mem_en;
	logic            instruction_finish;
	logic            done;

	cnn_pkg::word_t fmem [0:4095];
	cnn_pkg::word_t wmem [0:65535];
	row_t           prog [n_rows];
	int             errors = 0;
	int             watch_limit = 0;
	logic           watch_armed = 1'b0;
	int             mon_errors, mon_writes, mon_finishes, mon_pending;

	cnn_ctrl u_cnn_ctrl (
		.clk                (clk),
		.reset              (reset),
		.start              (start),
		.feature_idata      (feature_idata),
		.weight_idata       (weight_idata),
		.feature_addr       (feature_addr),
		.feature_data       (feature_data),
		.weight_addr        (weight_addr),
		.feature_mem_en     (feature_mem_en),
		.instruction_finish (instruction_finish),
		.done               (done)
	);

	write_monitor u_write_monitor (
		.clk                (clk),
		.reset              (reset),
		.feature_addr       (feature_addr),
		.feature_data       (feature_data),
		.feature_mem_en     (feature_mem_en),
		.instruction_finish (instruction_finish),
		.done               (done),
		.errors             (mon_errors),
		.writes             (mon_writes),
		.finishes           (mon_finishes),
		.pending            (mon_pending)
	);

	bind cnn_ctrl cnn_ctrl_chk u_chk (
		.clk                (clk),
		.reset              (reset),
		.feature_mem_en     (feature_mem_en),
		.instruction_finish (instruction_finish),
		.done               (done)
	);

	initial clk = 1'b0;
	always #(clk_half) clk = ~clk;

	// Memories read without a clock, feature writes land on the rising edge
	assign feature_idata = fmem[feature_addr];
	assign weight_idata  = wmem[weight_addr];

	always @(posedge clk) begin
		if (feature_mem_en)
			fmem[feature_addr] <= feature_data;
	end

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] expected);
		if (got !== expected) begin
			$display("ERR %s got %h expected %h", name, got, expected);
			errors++;
		end
	endtask

	task automatic check_quiet();
		check_value("feature_mem_en", feature_mem_en, 0);
		check_value("instruction_finish", instruction_finish, 0);
		check_value("done", done, 0);
		check_value("feature_addr", feature_addr, 0);
		check_value("weight_addr", weight_addr, 0);
	endtask

	function automatic cnn_pkg::word_t encode_row(input row_t r);
		cnn_pkg::word_t w;
		w = '0;
		w[cnn_pkg::op_hi:cnn_pkg::op_lo] = r.op;
		if (r.op == cnn_pkg::op_pool) begin
			w[cnn_pkg::pool_ch_hi:cnn_pkg::pool_ch_lo]     = r.cnt[7:0];
			w[cnn_pkg::pool_side_hi:cnn_pkg::pool_side_lo] = r.side[13:0];
		end else if (r.op == cnn_pkg::op_fc) begin
			w[cnn_pkg::fc_feat_hi:cnn_pkg::fc_feat_lo]   = r.cnt[7:0];
			w[cnn_pkg::fc_side_hi:cnn_pkg::fc_side_lo]   = r.side[5:0];
			w[cnn_pkg::fc_class_hi:cnn_pkg::fc_class_lo] = r.cls[3:0];
			w[cnn_pkg::fc_wbase_hi:cnn_pkg::fc_wbase_lo] = r.wbase[9:0];
		end
		return w;
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	task automatic model_pool(input row_t r, output int count);
		int             half;
		int             addr;
		cnn_pkg::word_t best;
		cnn_pkg::word_t v;
		count = 0;
		half  = r.side / cnn_pkg::pool_win;
		for (int c = 0; c < r.cnt; c++) begin
			for (int wy = 0; wy < half; wy++) begin
				for (int wx = 0; wx < half; wx++) begin
					for (int p = 0; p < cnn_pkg::pool_win * cnn_pkg::pool_win; p++) begin
						addr = c * r.side * r.side
						     + (wy * cnn_pkg::pool_win + p / cnn_pkg::pool_win) * r.side
						     + wx * cnn_pkg::pool_win + p % cnn_pkg::pool_win;
						v = fmem[addr];
						if (p == 0 || v > best)
							best = v;
					end
					u_write_monitor.expect_write(cnn_pkg::pool_out_base + count, best,
						c == r.cnt - 1 && wy == half - 1 && wx == half - 1);
					count++;
				end
			end
		end
	endtask

	task automatic model_fc(input row_t r, output int count);
		int     len;
		longint acc;
		count = 0;
		len   = r.cnt * r.side * r.side;
		for (int n = 0; n < r.cls; n++) begin
			acc = 0; // Each class sums on its own
			for (int i = 0; i < len; i++)
				acc += longint'(fmem[i]) * longint'(wmem[r.wbase + n * len + i]);
			u_write_monitor.expect_write(cnn_pkg::fc_out_base + count, acc[58:27],
			                             n == r.cls - 1);
			count++;
		end
	endtask

	initial begin
		int got_count;
		int total_writes;
		int layer_rows;
		int per_write;
		int chk_fails;
		int total_errors;
		start        = 1'b0;
		reset        = 1'b1;
		total_writes = 0;
		layer_rows   = 0;
		watch_limit  = 200;
		void'($urandom(32'hc1));
		for (int a = 0; a < 4096; a++)
			fmem[a] = $urandom;
		for (int a = 0; a < 65536; a++)
			wmem[a] = $urandom;

		prog[0] = '{cnn_pkg::op_pool, 2, 4, 0, 0, 8};
		prog[1] = '{cnn_pkg::op_fc, 2, 2, 3, 16, 3};
		prog[2] = '{cnn_pkg::op_pool, 1, 6, 0, 0, 9};
		prog[3] = '{cnn_pkg::op_fc, 1, 3, 4, 100, 4};
		prog[4] = '{cnn_pkg::op_end, 0, 0, 0, 0, 0};

		for (int k = 0; k < n_rows; k++) begin
			fmem[cnn_pkg::pc_reset - k] = encode_row(prog[k]); // Program grows downward
			got_count = 0;
			if (prog[k].op == cnn_pkg::op_pool) begin
				model_pool(prog[k], got_count);
				per_write = cnn_pkg::pool_win * cnn_pkg::pool_win + 4;
			end else if (prog[k].op == cnn_pkg::op_fc) begin
				model_fc(prog[k], got_count);
				per_write = prog[k].cnt * prog[k].side * prog[k].side + 4;
			end
			if (prog[k].op != cnn_pkg::op_end) begin
				layer_rows++;
				watch_limit += prog[k].writes * per_write;
			end
			if (got_count != prog[k].writes) begin
				$display("Row %0d of the program table expects %0d writes but the model makes %0d",
				         k, prog[k].writes, got_count);
				errors++;
			end
			total_writes += prog[k].writes;
		end
		watch_armed = 1'b1;

		repeat (reset_len / 2) @(posedge clk);
		@(negedge clk);
		check_quiet();
		repeat (reset_len / 2) @(posedge clk);
		#1 reset = 1'b0;
		@(negedge clk);
		check_quiet();

		@(posedge clk);
		#1 start = 1'b1;
		@(posedge clk);
		#1 start = 1'b0;
		@(negedge clk);
		check_value("feature_addr", feature_addr, cnn_pkg::pc_reset);

		wait (done);
		repeat (20) @(negedge clk); // Quiet period after END
		check_value("done", done, 1);
		check_value("write_count", mon_writes, total_writes);
		check_value("finish_count", mon_finishes, layer_rows);
		if (mon_pending != 0) begin
			$display("%0d expected writes never happened", mon_pending);
			errors++;
		end

		chk_fails    = u_cnn_ctrl.u_chk.fail_count;
		total_errors = errors + mon_errors + chk_fails;
		$display("Errors %0d (testbench %0d, monitor %0d, assertions %0d), writes %0d of %0d",
		         total_errors, errors, mon_errors, chk_fails, mon_writes, total_writes);
		if (total_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		wait (watch_armed);
		repeat (watch_limit) @(posedge clk);
		$display("Timeout: done did not rise within %0d cycles", watch_limit);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
logic/cnn_pkg.sv
logic/layer_cmd_if.sv
logic/engine_out_if.sv
logic/instr_fetch.sv
logic/pool_engine.sv
logic/fc_engine.sv
logic/result_writer.sv
logic/cnn_ctrl.sv
tb/cnn_ctrl_chk.sv
tb/write_monitor.sv
tb/cnn_ctrl_tb.sv
